/* tb/mem_wb_cases.txt */
# columns: kind op operand_a operand_b addr dest expected, all hex
# kind: 0 alu, 1 alu without write, 2 store, 3 cancelled store, 4 load, 5 divide
0 00 12345678 00000000 000 01 12345678
0 00 deadbeef 00000000 000 00 00000000
1 00 cafef00d 00000000 000 05 00000000
2 80 11223344 00000000 100 00 00000000
2 20 000000aa 00000000 101 00 00000000
2 20 000000bb 00000000 103 00 00000000
4 04 00000000 00000000 100 02 bb22aa44
2 40 0000ccdd 00000000 102 00 00000000
2 20 000000ee 00000000 100 00 00000000
2 20 00000099 00000000 102 00 00000000
2 40 00001234 00000000 100 00 00000000
4 04 00000000 00000000 100 03 cc991234
4 01 00000000 00000000 102 04 ffffff99
4 08 00000000 00000000 103 05 000000cc
4 01 00000000 00000000 103 06 ffffffcc
4 02 00000000 00000000 102 07 ffffcc99
4 10 00000000 00000000 100 08 00001234
3 80 ffffffff 00000000 100 00 00000000
4 04 00000000 00000000 100 09 cc991234
5 01 fffffff9 00000002 000 0a fffffffd
5 04 fffffff9 00000002 000 0b ffffffff
5 02 fffffff9 00000002 000 0c 7ffffffc
5 08 00000064 00000007 000 0d 00000002
5 01 00000064 00000000 000 0e ffffffff
5 04 fffffff0 00000000 000 0f fffffff0
5 01 0000000f fffffffc 000 10 fffffffd

/* all.f */
design/lsu_pkg.sv
design/div_unit.sv
design/mem_stage.sv
design/data_sram.sv
design/wb_stage.sv
design/mem_wb_top.sv
tb/mem_wb_assert.sv
tb/mem_wb_tb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' all.f)

.PHONY: run clean

obj_dir/Vmem_wb_tb: all.f $(SRCS)
	verilator --binary --timing --assert --top-module mem_wb_tb -f all.f

run: obj_dir/Vmem_wb_tb
	obj_dir/Vmem_wb_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -qF '** FAIL **' sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* tb/mem_wb_tb.sv */
`timescale 1ns/1ps

module mem_wb_tb;

    localparam int max_cases   = 64;
    localparam int rand_cases  = 6;
    localparam int sweep_cases = 12;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          in_valid;
    logic [31:0]                   pc;
    logic [31:0]                   result;
    logic [7:0]                    mem_op;
    logic [lsu_pkg::div_op_w-1:0]  div_op;
    logic                          res_from_div;
    logic                          res_from_mem;
    logic                          gr_we;
    logic                          mem_we;
    logic                          commit_ok;
    logic [4:0]                    dest;
    logic [31:0]                   rkd_value;
    logic                          in_ready;
    logic                          div_req_valid;
    logic [31:0]                   div_dividend;
    logic [31:0]                   div_divisor;
    logic [lsu_pkg::div_op_w-1:0]  div_req_op;
    logic                          div_req_ready;
    logic                          rf_we;
    logic [4:0]                    rf_waddr;
    logic [31:0]                   rf_wdata;
    logic [31:0]                   wb_pc;

    logic [31:0] c_kind [max_cases];
    logic [31:0] c_op   [max_cases];
    logic [31:0] c_a    [max_cases];
    logic [31:0] c_b    [max_cases];
    logic [31:0] c_addr [max_cases];
    logic [31:0] c_dest [max_cases];
    logic [31:0] c_exp  [max_cases];
    logic [31:0] ref_mem [logic [29:0]];
    // expected writes as {dest, value, pc}
    logic [68:0] exp_q [$];
    logic [68:0] e;
    logic [31:0] seed;
    // whether the last accepted instruction must write in the following cycle
    logic        last_wr = 1'b0;
    logic [7:0]  sweep_op;
    logic [31:0] sweep_word;
    int          sweep_idx = 0;
    string       line;
    int          fd;
    int          n = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 1000;

    mem_wb_top UUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // byte-lane rule for st.b, st.h and st.w
    function automatic logic [31:0] store_merge(input logic [31:0] old, input logic [7:0] op,
                                                input logic [1:0] off, input logic [31:0] d);
        logic [31:0] w;
        w = old;
        if (op[5]) begin
            w[8*off +: 8] = d[7:0];
        end else if (op[6]) begin
            w[16*off[1] +: 16] = d[15:0];
        end else if (op[7]) begin
            w = d;
        end
        return w;
    endfunction

    function automatic logic [31:0] load_extract(input logic [31:0] word, input logic [7:0] op,
                                                 input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = word[16*off[1] +: 16];
        case (op)
            8'h01:   return {{24{b[7]}}, b};
            8'h08:   return {24'd0, b};
            8'h02:   return {{16{h[15]}}, h};
            8'h10:   return {16'd0, h};
            default: return word;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    // called at a rising edge, returns at the edge that accepts the instruction
    task automatic send(input int idx, input logic [7:0] kind, input logic [7:0] op,
                        input logic [31:0] a, input logic [31:0] b, input logic [31:0] addr,
                        input logic [4:0] dst, input logic [31:0] exp);
        logic [31:0] cur_pc;
        logic [31:0] word;
        logic        wr;
        int          waits;
        cur_pc = 32'h1c00_1000 + 32'(idx) * 4;
        waits  = 0;
        wr     = (kind == 8'd0 || kind >= 8'd4) && dst != 5'd0;
        in_valid      <= 1'b1;
        pc            <= cur_pc;
        result        <= (kind <= 8'd1) ? a : addr;
        mem_op        <= (kind >= 8'd2 && kind <= 8'd4) ? op : 8'd0;
        div_op        <= (kind == 8'd5) ? op[3:0] : 4'd0;
        res_from_div  <= (kind == 8'd5);
        res_from_mem  <= (kind == 8'd4);
        gr_we         <= (kind == 8'd0 || kind == 8'd4 || kind == 8'd5);
        mem_we        <= (kind == 8'd2 || kind == 8'd3);
        commit_ok     <= (kind != 8'd3);
        dest          <= dst;
        rkd_value     <= a;
        div_req_valid <= (kind == 8'd5);
        div_dividend  <= a;
        div_divisor   <= b;
        div_req_op    <= op[3:0];
        word = ref_mem.exists(addr[31:2]) ? ref_mem[addr[31:2]] : 32'd0;
        if (kind == 8'd2) begin
            ref_mem[addr[31:2]] = store_merge(word, op, addr[1:0], a);
        end
        if (kind == 8'd4 && load_extract(word, op, addr[1:0]) !== exp) begin
            errors++;
            $display("case %0d: expected value in the cases file disagrees with memory", idx);
        end
        if (wr) begin
            exp_q.push_back({dst, exp, cur_pc});
        end
        @(negedge clk);
        // the previous instruction writes here and the divider is idle between divides
        check("rf_we", 32'(rf_we), 32'(last_wr));
        check("div_req_ready", 32'(div_req_ready), 32'd1);
        while (!in_ready) begin
            waits++;
            @(negedge clk);
            check("rf_we", 32'(rf_we), 32'd0);
            check("div_req_ready", 32'(div_req_ready), 32'd0);
        end
        if (kind == 8'd5 && waits == 0) begin
            errors++;
            $display("case %0d: divide was accepted without waiting for the divider", idx);
        end
        @(posedge clk);
        last_wr = wr;
    endtask

    // every write must match the oldest outstanding expectation
    always @(negedge clk) begin
        if (!rst && rf_we) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected register write to r%0d at pc %h", rf_waddr, wb_pc);
            end else begin
                e = exp_q.pop_front();
                check("rf_waddr", 32'(rf_waddr), 32'(e[68:64]));
                check("rf_wdata", rf_wdata, e[63:32]);
                check("wb_pc", wb_pc, e[31:0]);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, %0d writes still expected", cycles, exp_q.size());
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        rst           <= 1'b1;
        in_valid      <= 1'b0;
        pc            <= 32'd0;
        result        <= 32'd0;
        mem_op        <= 8'd0;
        div_op        <= 4'd0;
        res_from_div  <= 1'b0;
        res_from_mem  <= 1'b0;
        gr_we         <= 1'b0;
        mem_we        <= 1'b0;
        commit_ok     <= 1'b0;
        dest          <= 5'd0;
        rkd_value     <= 32'd0;
        div_req_valid <= 1'b0;
        div_dividend  <= 32'd0;
        div_divisor   <= 32'd0;
        div_req_op    <= 4'd0;
        seed = 32'd50070;
        fd = $fopen("tb/mem_wb_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tb/mem_wb_cases.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#" && n < max_cases) begin
                    if ($sscanf(line, "%h %h %h %h %h %h %h", c_kind[n], c_op[n], c_a[n],
                                c_b[n], c_addr[n], c_dest[n], c_exp[n]) == 7) begin
                        n++;
                    end
                end
            end
            $fclose(fd);
        end
        limit = 40 * (n + sweep_cases + rand_cases) + 20;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < n; i++) begin
            send(i, c_kind[i][7:0], c_op[i][7:0], c_a[i], c_b[i], c_addr[i], c_dest[i][4:0],
                 c_exp[i]);
        end
        // each sub-word load at each aligned offset of the word at 0x100
        for (int s = 0; s < 4; s++) begin
            case (s)
                0:       sweep_op = 8'h01;
                1:       sweep_op = 8'h08;
                2:       sweep_op = 8'h02;
                default: sweep_op = 8'h10;
            endcase
            for (int o = 0; o < 4; o = o + ((s < 2) ? 1 : 2)) begin
                sweep_word = ref_mem.exists(30'h40) ? ref_mem[30'h40] : 32'd0;
                send(n + sweep_idx, 8'd4, sweep_op, 32'd0, 32'd0, 32'h100 + 32'(o),
                     5'd17 + 5'(sweep_idx), load_extract(sweep_word, sweep_op, 2'(o)));
                sweep_idx++;
            end
        end
        // extra pass-through instructions with pseudo-random values
        for (int j = 0; j < rand_cases; j++) begin
            seed = xorshift(seed);
            send(n + sweep_cases + j, 8'd0, 8'd0, seed, 32'd0, 32'd0, seed[12:8], seed);
        end
        in_valid      <= 1'b0;
        div_req_valid <= 1'b0;
        @(negedge clk);
        check("rf_we", 32'(rf_we), 32'(last_wr));
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* tb/mem_wb_assert.sv */
`timescale 1ns/1ps

module mem_wb_assert (
    input logic       clk,
    input logic       rst,
    input logic       in_valid,
    input logic       mem_we,
    input logic       commit_ok,
    input logic       in_ready,
    input logic       div_resp_valid,
    input logic       div_resp_ready,
    input logic [3:0] sram_we,
    input logic       ms_valid
);

    // byte enables only move for a committed store that the stage accepts
    no_store_no_we: assert property (@(posedge clk) disable iff (rst)
        !(in_valid && in_ready && mem_we && commit_ok) |-> sram_we == 4'b0000)
        else $error("sram_we active without an accepted store");

    // a response taken by the stage is gone on the next cycle
    resp_dropped_after_take: assert property (@(posedge clk) disable iff (rst)
        div_resp_valid && div_resp_ready |=> !div_resp_valid)
        else $error("div_resp_valid still high after the response was taken");

    // reset leaves the stage and the divider empty
    idle_after_reset: assert property (@(posedge clk) rst |=> !ms_valid && !div_resp_valid)
        else $error("stage or divider not idle after reset");

endmodule

bind mem_stage mem_wb_assert u_assert (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .mem_we         (mem_we),
    .commit_ok      (commit_ok),
    .in_ready       (in_ready),
    .div_resp_valid (div_resp_valid),
    .div_resp_ready (div_resp_ready),
    .sram_we        (sram_we),
    .ms_valid       (ms_valid)
);

/* design/mem_wb_top.sv */
`timescale 1ns/1ps

module mem_wb_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  logic [31:0]                   pc,
    input  logic [31:0]                   result,
    input  logic [7:0]                    mem_op,
    input  logic [lsu_pkg::div_op_w-1:0]  div_op,
    input  logic                          res_from_div,
    input  logic                          res_from_mem,
    input  logic                          gr_we,
    input  logic                          mem_we,
    input  logic                          commit_ok,
    input  logic [4:0]                    dest,
    input  logic [31:0]                   rkd_value,
    output logic                          in_ready,
    input  logic                          div_req_valid,
    input  logic [31:0]                   div_dividend,
    input  logic [31:0]                   div_divisor,
    input  logic [lsu_pkg::div_op_w-1:0]  div_req_op,
    output logic                          div_req_ready,
    output logic                          rf_we,
    output logic [4:0]                    rf_waddr,
    output logic [31:0]                   rf_wdata,
    output logic [31:0]                   wb_pc
);

    logic                        div_resp_valid;
    logic                        div_resp_ready;
    logic [31:0]                 div_quotient;
    logic [31:0]                 div_remainder;
    logic [3:0]                  sram_we;
    logic [lsu_pkg::sram_aw-1:0] sram_addr;
    logic [31:0]                 sram_wdata;
    logic [31:0]                 sram_rdata;
    logic                        ms_valid;
    logic [31:0]                 ms_pc;
    logic [31:0]                 ms_result;
    logic [7:0]                  ms_mem_op;
    logic                        ms_res_from_mem;
    logic                        ms_gr_we;
    logic [4:0]                  ms_dest;

    div_unit u_div (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (div_req_valid),
        .dividend   (div_dividend),
        .divisor    (div_divisor),
        .op         (div_req_op),
        .resp_ready (div_resp_ready),
        .req_ready  (div_req_ready),
        .resp_valid (div_resp_valid),
        .quotient   (div_quotient),
        .remainder  (div_remainder)
    );

    mem_stage u_mem (
        .clk             (clk),
        .rst             (rst),
        .in_valid        (in_valid),
        .pc              (pc),
        .result          (result),
        .mem_op          (mem_op),
        .div_op          (div_op),
        .res_from_div    (res_from_div),
        .res_from_mem    (res_from_mem),
        .gr_we           (gr_we),
        .mem_we          (mem_we),
        .commit_ok       (commit_ok),
        .dest            (dest),
        .rkd_value       (rkd_value),
        .div_resp_valid  (div_resp_valid),
        .div_quotient    (div_quotient),
        .div_remainder   (div_remainder),
        .in_ready        (in_ready),
        .div_resp_ready  (div_resp_ready),
        .sram_we         (sram_we),
        .sram_addr       (sram_addr),
        .sram_wdata      (sram_wdata),
        .ms_valid        (ms_valid),
        .ms_pc           (ms_pc),
        .ms_result       (ms_result),
        .ms_mem_op       (ms_mem_op),
        .ms_res_from_mem (ms_res_from_mem),
        .ms_gr_we        (ms_gr_we),
        .ms_dest         (ms_dest)
    );

    data_sram u_sram (
        .clk   (clk),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    wb_stage u_wb (
        .ms_valid        (ms_valid),
        .ms_pc           (ms_pc),
        .ms_result       (ms_result),
        .ms_mem_op       (ms_mem_op),
        .ms_res_from_mem (ms_res_from_mem),
        .ms_gr_we        (ms_gr_we),
        .ms_dest         (ms_dest),
        .sram_rdata      (sram_rdata),
        .rf_we           (rf_we),
        .rf_waddr        (rf_waddr),
        .rf_wdata        (rf_wdata),
        .wb_pc           (wb_pc)
    );

endmodule

/* design/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage (
    input  logic        ms_valid,
    input  logic [31:0] ms_pc,
    input  logic [31:0] ms_result,
    input  logic [7:0]  ms_mem_op,
    input  logic        ms_res_from_mem,
    input  logic        ms_gr_we,
    input  logic [4:0]  ms_dest,
    input  logic [31:0] sram_rdata,
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic [31:0] wb_pc
);

    lsu_pkg::mem_op_u op_dec;
    logic [7:0]       ld_byte;
    logic [15:0]      ld_half;
    logic [31:0]      ld_data;

    assign op_dec.bits = ms_mem_op;

    // the low address bits of the result pick the lane
    always_comb begin
        case (ms_result[1:0])
            2'b00:   ld_byte = sram_rdata[7:0];
            2'b01:   ld_byte = sram_rdata[15:8];
            2'b10:   ld_byte = sram_rdata[23:16];
            default: ld_byte = sram_rdata[31:24];
        endcase
    end

    assign ld_half = ms_result[1] ? sram_rdata[31:16] : sram_rdata[15:0];

    always_comb begin
        ld_data = 32'd0;
        if (op_dec.f.ld_b) begin
            ld_data = {{24{ld_byte[7]}}, ld_byte};
        end else if (op_dec.f.ld_bu) begin
            ld_data = {24'd0, ld_byte};
        end else if (op_dec.f.ld_h) begin
            ld_data = {{16{ld_half[15]}}, ld_half};
        end else if (op_dec.f.ld_hu) begin
            ld_data = {16'd0, ld_half};
        end else if (op_dec.f.ld_w) begin
            ld_data = sram_rdata;
        end
    end

    // register 0 is hardwired, so writes to it are dropped here
    assign rf_we    = ms_valid & ms_gr_we & (ms_dest != 5'd0);
    assign rf_waddr = ms_dest;
    assign rf_wdata = ms_res_from_mem ? ld_data : ms_result;
    assign wb_pc    = ms_pc;

endmodule

/* design/data_sram.sv */
`timescale 1ns/1ps

module data_sram (
    input  logic                         clk,
    input  logic [3:0]                   we,
    input  logic [lsu_pkg::sram_aw-1:0]  addr,
    input  logic [31:0]                  wdata,
    output logic [31:0]                  rdata
);

    logic [31:0] mem [0:(1 << lsu_pkg::sram_aw)-1];

    // read returns the old word when the same address is written on that edge
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                mem[addr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
        rdata <= mem[addr];
    end

endmodule

/* design/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  logic [31:0]                   pc,
    input  logic [31:0]                   result,
    input  logic [7:0]                    mem_op,
    input  logic [lsu_pkg::div_op_w-1:0]  div_op,
    input  logic                          res_from_div,
    input  logic                          res_from_mem,
    input  logic                          gr_we,
    input  logic                          mem_we,
    input  logic                          commit_ok,
    input  logic [4:0]                    dest,
    input  logic [31:0]                   rkd_value,
    input  logic                          div_resp_valid,
    input  logic [31:0]                   div_quotient,
    input  logic [31:0]                   div_remainder,
    output logic                          in_ready,
    output logic                          div_resp_ready,
    output logic [3:0]                    sram_we,
    output logic [lsu_pkg::sram_aw-1:0]   sram_addr,
    output logic [31:0]                   sram_wdata,
    output logic                          ms_valid,
    output logic [31:0]                   ms_pc,
    output logic [31:0]                   ms_result,
    output logic [7:0]                    ms_mem_op,
    output logic                          ms_res_from_mem,
    output logic                          ms_gr_we,
    output logic [4:0]                    ms_dest
);

    lsu_pkg::mem_op_u op_dec;
    logic             ready_go;
    logic             advance;
    logic             st_en;
    logic [3:0]       lane_we;
    logic             sel_q;
    logic             sel_r;
    logic [31:0]      result_d;

    assign op_dec.bits = mem_op;

    // a divide holds the stage until its response is there
    assign ready_go       = ~res_from_div | div_resp_valid;
    assign in_ready       = ~rst & (~in_valid | ready_go);
    assign advance        = in_valid & in_ready;
    assign div_resp_ready = advance & res_from_div;

    assign st_en = in_valid & mem_we & commit_ok;

    // data is replicated across the word, the byte enables pick the lanes
    always_comb begin
        lane_we    = 4'b0000;
        sram_wdata = rkd_value;
        if (op_dec.f.st_b) begin
            lane_we    = 4'b0001 << result[1:0];
            sram_wdata = {4{rkd_value[7:0]}};
        end else if (op_dec.f.st_h) begin
            lane_we    = result[1] ? 4'b1100 : 4'b0011;
            sram_wdata = {2{rkd_value[15:0]}};
        end else if (op_dec.f.st_w) begin
            lane_we = 4'b1111;
        end
    end

    assign sram_we   = st_en ? lane_we : 4'b0000;
    assign sram_addr = result[lsu_pkg::sram_aw+1:2];

    assign sel_q    = div_op[lsu_pkg::div_w_bit] | div_op[lsu_pkg::div_wu_bit];
    assign sel_r    = div_op[lsu_pkg::mod_w_bit] | div_op[lsu_pkg::mod_wu_bit];
    assign result_d = res_from_div ? (({32{sel_q}} & div_quotient) |
                                      ({32{sel_r}} & div_remainder))
                                   : result;

    // write-back never stalls, so every advance reaches the output registers
    always_ff @(posedge clk) begin
        if (rst) begin
            ms_valid <= 1'b0;
        end else begin
            ms_valid <= advance;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ms_pc           <= lsu_pkg::reset_pc;
            ms_mem_op       <= 8'd0;
            ms_res_from_mem <= 1'b0;
            ms_gr_we        <= 1'b0;
        end else if (advance) begin
            ms_pc           <= pc;
            ms_mem_op       <= mem_op;
            ms_res_from_mem <= res_from_mem;
            ms_gr_we        <= gr_we;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ms_result <= result_d;
            ms_dest   <= dest;
        end
    end

endmodule

/* design/div_unit.sv */
`timescale 1ns/1ps

module div_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  logic [31:0]                   dividend,
    input  logic [31:0]                   divisor,
    input  logic [lsu_pkg::div_op_w-1:0]  op,
    input  logic                          resp_ready,
    output logic                          req_ready,
    output logic                          resp_valid,
    output logic [31:0]                   quotient,
    output logic [31:0]                   remainder
);

    logic        busy;
    logic [5:0]  step;
    logic [31:0] quo;
    logic [31:0] rem;
    logic [31:0] dsor;
    logic        neg_q;
    logic        neg_r;
    logic        signed_op;
    logic [31:0] dend_abs;
    logic [31:0] dsor_abs;
    logic [32:0] rem_shift;
    logic [32:0] rem_diff;

    assign req_ready = ~busy & ~resp_valid;
    assign signed_op = op[lsu_pkg::div_w_bit] | op[lsu_pkg::mod_w_bit];
    assign dend_abs  = (signed_op && dividend[31]) ? -dividend : dividend;
    assign dsor_abs  = (signed_op && divisor[31]) ? -divisor : divisor;

    // restoring step: bring in the next dividend bit and try to subtract
    assign rem_shift = {rem, quo[31]};
    assign rem_diff  = rem_shift - {1'b0, dsor};

    // steps run while step counts 0..31, the sign fix happens at step 32
    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            resp_valid <= 1'b0;
            step       <= 6'd0;
        end else if (req_valid && req_ready) begin
            busy <= 1'b1;
            step <= 6'd0;
        end else if (busy) begin
            if (step == 6'd32) begin
                busy       <= 1'b0;
                resp_valid <= 1'b1;
            end
            step <= step + 6'd1;
        end else if (resp_valid && resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            quo   <= dend_abs;
            rem   <= 32'd0;
            dsor  <= dsor_abs;
            // a zero divisor keeps its all-ones quotient whatever the signs
            neg_q <= signed_op & (dividend[31] ^ divisor[31]) & (|divisor);
            neg_r <= signed_op & dividend[31];
        end else if (busy) begin
            if (step == 6'd32) begin
                if (neg_q) begin
                    quo <= -quo;
                end
                if (neg_r) begin
                    rem <= -rem;
                end
            end else if (rem_diff[32]) begin
                rem <= rem_shift[31:0];
                quo <= {quo[30:0], 1'b0};
            end else begin
                rem <= rem_diff[31:0];
                quo <= {quo[30:0], 1'b1};
            end
        end
    end

    assign quotient  = quo;
    assign remainder = rem;

endmodule

/* design/lsu_pkg.sv */
package lsu_pkg;

    // one-hot memory opcode, seen either as a raw word or as named flags
    // zero means the instruction does not touch memory
    typedef union packed {
        logic [7:0] bits;
        struct packed {
            logic st_w;
            logic st_h;
            logic st_b;
            logic ld_hu;
            logic ld_bu;
            logic ld_w;
            logic ld_h;
            logic ld_b;
        } f;
    } mem_op_u;

    // one-hot divide opcode
    localparam int div_op_w   = 4;
    localparam int div_w_bit  = 0;
    localparam int div_wu_bit = 1;
    localparam int mod_w_bit  = 2;
    localparam int mod_wu_bit = 3;

    // pc held in the stage registers after reset
    localparam logic [31:0] reset_pc = 32'h1c00_0000;

    // data SRAM word-address width, 1024 words
    localparam int sram_aw = 10;

endpackage
